// File: verilog.f
rename_pkg.sv
fp_free_list.sv
fp_rename_table.sv
fp_rename_stage.sv
tb_fp_rename.sv

// File: run.sh
#!/bin/sh
# Compile and run the FP rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_fp_rename -o tb_fp_rename
./obj_dir/tb_fp_rename > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: tb_fp_rename.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One table step per clock with its response checked on the next cycle
// Expected registers assume the reset free-list order 32..63
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_fp_rename
    import rename_pkg::*;
();

    typedef struct packed {
        rename_req_t              req;
        wb_t [NUM_FP_WB-1:0]      wb;
        commit_t [NUM_COMMIT-1:0] cm;
        recover_op_e              op;
        checkpoint_ptr            label;
        logic                     del;
        rename_rsp_t              exp;
        logic                     exp_stall;
        logic                     exp_ooc;
    } step_t;

    logic                     clk_i;
    logic                     rstn_i;
    rename_req_t              req;
    wb_t [NUM_FP_WB-1:0]      wb;
    commit_t [NUM_COMMIT-1:0] commit;
    recover_op_e              recover_op;
    checkpoint_ptr            recover_label;
    logic                     delete_ckpt;
    rename_rsp_t              rsp;
    logic                     stall;
    logic                     ooc;

    step_t steps [$];
    step_t nxt;           // Step under construction with side inputs set ahead of its request
    logic  ooc_level;     // out_of_checkpoints level expected for new steps
    int    errors;

    fp_rename_stage u_dut (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req),
        .wb_i                 (wb),
        .commit_i             (commit),
        .recover_op_i         (recover_op),
        .recover_label_i      (recover_label),
        .delete_checkpoint_i  (delete_ckpt),
        .rsp_o                (rsp),
        .stall_o              (stall),
        .out_of_checkpoints_o (ooc)
    );

    always #20 clk_i = ~clk_i;

    task automatic push_next();
        nxt.exp_ooc = ooc_level;
        steps.push_back(nxt);
        nxt = '0;
    endtask

    task automatic rename_dst(input int dst, input int ckpt, input int old_p, input int new_p,
                              input int lbl, input int stalls);
        nxt.req.valid         = 1'b1;
        nxt.req.dst           = reg_t'(dst);
        nxt.req.write_dst     = 1'b1;
        nxt.req.do_checkpoint = (ckpt != 0);
        nxt.exp.valid         = (stalls == 0);   // Stalled request gives no response
        nxt.exp.rdy1          = 1'b1;            // Unused sources read as ready
        nxt.exp.rdy2          = 1'b1;
        nxt.exp.rdy3          = 1'b1;
        nxt.exp.old_dst       = phreg_t'(old_p);
        nxt.exp.new_dst       = phreg_t'(new_p);
        nxt.exp.checkpoint    = checkpoint_ptr'(lbl);
        nxt.exp_stall         = (stalls != 0);
        push_next();
    endtask

    task automatic lookup_srcs(input int a, input int b, input int c, input int pa,
                               input int pb, input int pc, input logic [2:0] rdy);
        nxt.req.valid   = 1'b1;
        nxt.req.src1    = reg_t'(a);
        nxt.req.src2    = reg_t'(b);
        nxt.req.src3    = reg_t'(c);
        nxt.req.use_fs1 = 1'b1;
        nxt.req.use_fs2 = 1'b1;
        nxt.req.use_fs3 = 1'b1;
        nxt.exp.valid   = 1'b1;
        nxt.exp.src1    = phreg_t'(pa);
        nxt.exp.src2    = phreg_t'(pb);
        nxt.exp.src3    = phreg_t'(pc);
        nxt.exp.rdy1    = rdy[2];
        nxt.exp.rdy2    = rdy[1];
        nxt.exp.rdy3    = rdy[0];
        push_next();
    endtask

    task automatic idle_cycle();
        push_next();
    endtask

    task automatic writeback_on(input int port, input int vaddr, input int paddr);
        nxt.wb[port].valid = 1'b1;
        nxt.wb[port].vaddr = reg_t'(vaddr);
        nxt.wb[port].paddr = phreg_t'(paddr);
    endtask

    task automatic commit_on(input int slot, input int arch, input int new_p, input int free_p);
        nxt.cm[slot].valid    = 1'b1;
        nxt.cm[slot].old_dst  = reg_t'(arch);
        nxt.cm[slot].new_dst  = phreg_t'(new_p);
        nxt.cm[slot].free_reg = phreg_t'(free_p);
    endtask

    task automatic recover_on(input recover_op_e op, input int lbl);
        nxt.op    = op;
        nxt.label = checkpoint_ptr'(lbl);
    endtask

    task automatic delete_on();
        nxt.del = 1'b1;
    endtask

    task automatic build_table();
        int a;
        int b;
        int c;
        // Right after reset any lookup sees the identity map
        for (int i = 0; i < 4; i++) begin
            a = int'($urandom % NUM_ISA_REGISTERS);
            b = int'($urandom % NUM_ISA_REGISTERS);
            c = int'($urandom % NUM_ISA_REGISTERS);
            lookup_srcs(a, b, c, a, b, c, 3'b111);
        end
        rename_dst(1, 0, 1, 32, 0, 0);
        rename_dst(1, 0, 32, 33, 0, 0);
        rename_dst(2, 0, 2, 34, 0, 0);
        writeback_on(0, 2, 34);     // Bypassed into this lookup
        writeback_on(1, 1, 32);     // Stale since f1 maps to 33 by now
        lookup_srcs(1, 2, 3, 33, 34, 3, 3'b011);
        lookup_srcs(1, 2, 3, 33, 34, 3, 3'b011);
        writeback_on(0, 1, 33);
        lookup_srcs(1, 2, 3, 33, 34, 3, 3'b111);
        // Checkpoint on f4 and two younger renames before going back to label 0
        rename_dst(4, 1, 4, 35, 0, 0);
        rename_dst(5, 0, 5, 36, 0, 0);
        rename_dst(1, 0, 33, 37, 0, 0);
        recover_on(REC_CHECKPOINT, 0);
        idle_cycle();
        lookup_srcs(4, 5, 1, 35, 5, 33, 3'b011);
        rename_dst(6, 0, 6, 36, 0, 0);
        // Three live checkpoints leave no spare copy
        rename_dst(7, 1, 7, 37, 0, 0);
        rename_dst(8, 1, 8, 38, 1, 0);
        rename_dst(9, 1, 9, 39, 2, 0);
        ooc_level = 1'b1;
        rename_dst(10, 1, 10, 40, 0, 1);
        delete_on();
        rename_dst(10, 1, 10, 40, 0, 1);
        ooc_level = 1'b0;
        rename_dst(10, 1, 10, 40, 3, 0);
        ooc_level = 1'b1;
        // Later slot wins for f1 committed twice in one cycle
        commit_on(0, 1, 32, 1);
        commit_on(1, 1, 33, 32);
        idle_cycle();
        commit_on(0, 2, 34, 2);
        commit_on(1, 4, 35, 4);
        idle_cycle();
        recover_on(REC_COMMIT, 0);
        idle_cycle();
        ooc_level = 1'b0;
        lookup_srcs(1, 2, 4, 33, 34, 35, 3'b111);
        lookup_srcs(3, 5, 6, 3, 5, 6, 3'b111);
        // Free entries 36..63 drain before the registers freed by commit
        for (int i = 0; i < 28; i++) begin
            rename_dst(i + 4, 0, (i == 0) ? 35 : i + 4, i + 36, 0, 0);
        end
        rename_dst(1, 0, 33, 1, 0, 0);
        rename_dst(2, 0, 34, 32, 0, 0);
        idle_cycle();
    endtask

    task automatic apply_step(input step_t s);
        req           <= s.req;
        wb            <= s.wb;
        commit        <= s.cm;
        recover_op    <= s.op;
        recover_label <= s.label;
        delete_ckpt   <= s.del;
    endtask

    task automatic mismatch(input int idx, input string what, input int got, input int expv);
        errors++;
        $display("FAILED at %0t ns: step %0d %s is %0d, expected %0d",
                 $time, idx, what, got, expv);
    endtask

    task automatic check_levels(input int idx, input step_t s);
        if (stall !== s.exp_stall) mismatch(idx, "stall_o", stall, s.exp_stall);
        if (ooc !== s.exp_ooc) mismatch(idx, "out_of_checkpoints_o", ooc, s.exp_ooc);
    endtask

    task automatic check_response(input int idx, input step_t s);
        rename_req_t q;
        rename_rsp_t e;
        q = s.req;
        e = s.exp;
        if (rsp.valid !== e.valid) begin
            mismatch(idx, "rsp valid", rsp.valid, e.valid);
        end else if (e.valid) begin
            if (q.use_fs1 && rsp.src1 !== e.src1) mismatch(idx, "src1", rsp.src1, e.src1);
            if (q.use_fs2 && rsp.src2 !== e.src2) mismatch(idx, "src2", rsp.src2, e.src2);
            if (q.use_fs3 && rsp.src3 !== e.src3) mismatch(idx, "src3", rsp.src3, e.src3);
            if (rsp.rdy1 !== e.rdy1) mismatch(idx, "rdy1", rsp.rdy1, e.rdy1);
            if (rsp.rdy2 !== e.rdy2) mismatch(idx, "rdy2", rsp.rdy2, e.rdy2);
            if (rsp.rdy3 !== e.rdy3) mismatch(idx, "rdy3", rsp.rdy3, e.rdy3);
            if (q.write_dst) begin
                if (rsp.old_dst !== e.old_dst) mismatch(idx, "old_dst", rsp.old_dst, e.old_dst);
                if (rsp.new_dst !== e.new_dst) mismatch(idx, "new_dst", rsp.new_dst, e.new_dst);
            end
            if (q.do_checkpoint && rsp.checkpoint !== e.checkpoint) begin
                mismatch(idx, "checkpoint", rsp.checkpoint, e.checkpoint);
            end
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rstn_i !== 1'b1 && cycles < 10) begin
            @(posedge clk_i);
            cycles++;
        end
        if (rstn_i !== 1'b1) begin
            errors++;
            $display("Timeout: reset was not released within 10 clock cycles");
        end
    endtask

    initial begin
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        req           = '0;
        wb            = '0;
        commit        = '0;
        recover_op    = REC_NONE;
        recover_label = '0;
        delete_ckpt   = 1'b0;
        nxt           = '0;
        ooc_level     = 1'b0;
        errors        = 0;
        void'($urandom(57264));
        build_table();

        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
        wait_reset_release();

        if (errors == 0) begin
            for (int i = 0; i < steps.size(); i++) begin
                @(posedge clk_i);
                apply_step(steps[i]);
                @(negedge clk_i);   // Levels for this step and the response of the one before
                check_levels(i, steps[i]);
                if (i > 0) check_response(i - 1, steps[i - 1]);
            end
        end

        $display("Ran %0d steps, %0d error(s)", steps.size(), errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: fp_rename_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stalled requests must be held by the source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_rename_stage
    import rename_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  rename_req_t                req_i,
    input  wb_t [NUM_FP_WB-1:0]        wb_i,
    input  commit_t [NUM_COMMIT-1:0]   commit_i,
    input  recover_op_e                recover_op_i,
    input  checkpoint_ptr              recover_label_i,
    input  logic                       delete_checkpoint_i,
    output rename_rsp_t                rsp_o,
    output logic                       stall_o,
    output logic                       out_of_checkpoints_o
);

    logic   accept;
    logic   fl_empty;
    logic   fl_pop;
    logic   fl_checkpoint;
    phreg_t new_dst;

    // No free register, or no checkpoint copy left for a branch
    assign stall_o = req_i.valid & ((fl_empty & req_i.write_dst)
                     | (req_i.do_checkpoint & out_of_checkpoints_o));

    assign accept        = req_i.valid & ~stall_o & (recover_op_i == REC_NONE);
    assign fl_pop        = accept & req_i.write_dst;
    assign fl_checkpoint = accept & req_i.do_checkpoint;

    fp_free_list u_free_list (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .pop_i               (fl_pop),
        .do_checkpoint_i     (fl_checkpoint),
        .push_i              (commit_i),   // free_reg of each slot
        .recover_op_i        (recover_op_i),
        .recover_label_i     (recover_label_i),
        .delete_checkpoint_i (delete_checkpoint_i),
        .new_dst_o           (new_dst),
        .empty_o             (fl_empty)
    );

    fp_rename_table u_rename_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .accept_i             (accept),
        .new_dst_i            (new_dst),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recover_op_i         (recover_op_i),
        .recover_label_i      (recover_label_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .rsp_o                (rsp_o),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

endmodule

// File: fp_rename_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One rename per cycle with lookups done before the dst write
// Recovery to a label that was never issued is not checked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_rename_table
    import rename_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  rename_req_t                req_i,
    input  logic                       accept_i,
    input  phreg_t                     new_dst_i,
    input  wb_t [NUM_FP_WB-1:0]        wb_i,
    input  commit_t [NUM_COMMIT-1:0]   commit_i,
    input  recover_op_e                recover_op_i,
    input  checkpoint_ptr              recover_label_i,
    input  logic                       delete_checkpoint_i,
    output rename_rsp_t                rsp_o,
    output logic                       out_of_checkpoints_o
);

    // One map and ready copy per checkpoint version
    phreg_t        map_q    [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t        map_d    [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic          ready_q  [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic          ready_d  [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t        commit_q [NUM_ISA_REGISTERS];
    phreg_t        commit_d [NUM_ISA_REGISTERS];

    checkpoint_ptr head_q, head_d;     // Version in use for lookups
    checkpoint_ptr tail_q, tail_d;     // Oldest live checkpoint
    checkpoint_ptr next_ver;
    ckpt_count_t   num_ckpt_q, num_ckpt_d;

    logic          write_en;
    logic          ckpt_en;

    reg_t          src_arch [3];
    logic          src_use  [3];
    phreg_t        src_phys [3];
    logic          src_rdy  [3];
    logic          bypass;
    rename_rsp_t   rsp_d, rsp_q;

    assign next_ver = head_q + checkpoint_ptr'(1);
    assign write_en = accept_i & req_i.write_dst;
    assign ckpt_en  = accept_i & req_i.do_checkpoint & ~out_of_checkpoints_o;

    always_comb begin
        map_d      = map_q;
        ready_d    = ready_q;
        commit_d   = commit_q;
        head_d     = head_q;
        tail_d     = tail_q + checkpoint_ptr'(delete_checkpoint_i);
        num_ckpt_d = num_ckpt_q + ckpt_count_t'(ckpt_en)
                     - ckpt_count_t'(delete_checkpoint_i);

        // Wake every version that still maps vaddr to paddr
        for (int i = 0; i < NUM_FP_WB; i++) begin
            if (wb_i[i].valid) begin
                for (int j = 0; j < NUM_CHECKPOINTS; j++) begin
                    if (map_q[j][wb_i[i].vaddr] == wb_i[i].paddr) begin
                        ready_d[j][wb_i[i].vaddr] = 1'b1;
                    end
                end
            end
        end

        // Branch copy first, so the rename lands in both versions
        if (ckpt_en) begin
            map_d[next_ver]   = map_d[head_q];
            ready_d[next_ver] = ready_d[head_q];
            head_d            = next_ver;
        end

        if (write_en) begin
            map_d[head_q][req_i.dst]   = new_dst_i;
            ready_d[head_q][req_i.dst] = 1'b0;
            if (ckpt_en) begin
                map_d[next_ver][req_i.dst]   = new_dst_i;
                ready_d[next_ver][req_i.dst] = 1'b0;
            end
        end

        // Later slot wins on the same register
        for (int i = 0; i < NUM_COMMIT; i++) begin
            if (commit_i[i].valid) commit_d[commit_i[i].old_dst] = commit_i[i].new_dst;
        end

        case (recover_op_i)
            REC_CHECKPOINT: begin
                head_d     = recover_label_i;
                num_ckpt_d = {1'b0, recover_label_i - tail_d};
            end
            REC_COMMIT: begin
                for (int k = 0; k < NUM_ISA_REGISTERS; k++) begin
                    map_d[0][k]   = commit_q[k];
                    ready_d[0][k] = 1'b1;
                end
                commit_d   = commit_q;   // Commits held off during exception flush
                head_d     = '0;
                tail_d     = '0;
                num_ckpt_d = '0;
            end
            default: ;
        endcase
    end

    // Source lookup with same-cycle writeback bypass
    always_comb begin
        src_arch[0] = req_i.src1;
        src_arch[1] = req_i.src2;
        src_arch[2] = req_i.src3;
        src_use[0]  = req_i.use_fs1;
        src_use[1]  = req_i.use_fs2;
        src_use[2]  = req_i.use_fs3;
        for (int s = 0; s < 3; s++) begin
            src_phys[s] = map_q[head_q][src_arch[s]];
            bypass      = 1'b0;
            for (int w = 0; w < NUM_FP_WB; w++) begin
                bypass |= wb_i[w].valid & (wb_i[w].vaddr == src_arch[s])
                          & (wb_i[w].paddr == src_phys[s]);
            end
            src_rdy[s] = ready_q[head_q][src_arch[s]] | bypass | ~src_use[s];
        end

        rsp_d.valid      = 1'b1;
        rsp_d.src1       = src_phys[0];
        rsp_d.src2       = src_phys[1];
        rsp_d.src3       = src_phys[2];
        rsp_d.rdy1       = src_rdy[0];
        rsp_d.rdy2       = src_rdy[1];
        rsp_d.rdy3       = src_rdy[2];
        rsp_d.old_dst    = map_q[head_q][req_i.dst];
        rsp_d.new_dst    = new_dst_i;
        rsp_d.checkpoint = head_q;   // Recovering here restores the state after this rename
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int j = 0; j < NUM_CHECKPOINTS; j++) begin
                for (int k = 0; k < NUM_ISA_REGISTERS; k++) begin
                    map_q[j][k]   <= phreg_t'(k);   // Identity map
                    ready_q[j][k] <= 1'b1;
                end
            end
            for (int k = 0; k < NUM_ISA_REGISTERS; k++) begin
                commit_q[k] <= phreg_t'(k);
            end
            head_q     <= '0;
            tail_q     <= '0;
            num_ckpt_q <= '0;
            rsp_q      <= '0;
        end else begin
            map_q      <= map_d;
            ready_q    <= ready_d;
            commit_q   <= commit_d;
            head_q     <= head_d;
            tail_q     <= tail_d;
            num_ckpt_q <= num_ckpt_d;
            if (accept_i) begin
                rsp_q <= rsp_d;
            end else begin
                rsp_q.valid <= 1'b0;   // Payload held, only valid drops
            end
        end
    end

    assign rsp_o = rsp_q;

    // Last copy is kept for the live map
    assign out_of_checkpoints_o = (num_ckpt_q == ckpt_count_t'(NUM_CHECKPOINTS - 1));

endmodule

// File: fp_free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pop is ignored when empty; pushes assume in-order commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_free_list
    import rename_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       pop_i,
    input  logic                       do_checkpoint_i,
    input  commit_t [NUM_COMMIT-1:0]   push_i,
    input  recover_op_e                recover_op_i,
    input  checkpoint_ptr              recover_label_i,
    input  logic                       delete_checkpoint_i,
    output phreg_t                     new_dst_o,
    output logic                       empty_o
);

    // Buffer is as deep as the register file, so pointers are phreg_t wide
    phreg_t        entries_q [NUM_PHYS_REGISTERS];
    phreg_t        head_q, head_d;
    phreg_t        tail_q, tail_d;
    phreg_t        head_popped;
    fl_count_t     count_q, count_d;
    phreg_t        saved_head_q [NUM_CHECKPOINTS];
    checkpoint_ptr label_q, label_d;
    checkpoint_ptr oldest_q, oldest_d;
    ckpt_count_t   num_ckpt_q, num_ckpt_d;
    logic          do_pop;
    logic          ckpt_en;
    logic [$clog2(NUM_COMMIT):0] num_push;
    logic          push_en  [NUM_COMMIT];
    phreg_t        push_ptr [NUM_COMMIT];

    assign do_pop      = pop_i & (count_q != '0);
    assign head_popped = head_q + phreg_t'(do_pop);
    assign ckpt_en     = do_checkpoint_i & (num_ckpt_q < NUM_CHECKPOINTS - 1)
                         & (recover_op_i == REC_NONE);   // Label counter stays in step with the table

    // Freed registers fill the tail in slot order
    always_comb begin
        num_push = '0;
        for (int i = 0; i < NUM_COMMIT; i++) begin
            push_en[i]  = push_i[i].valid & (recover_op_i != REC_COMMIT);
            push_ptr[i] = tail_q + phreg_t'(num_push);
            num_push    = num_push + push_en[i];
        end
    end

    always_comb begin
        head_d     = head_popped;
        tail_d     = tail_q + phreg_t'(num_push);
        count_d    = count_q + fl_count_t'(num_push) - fl_count_t'(do_pop);
        label_d    = label_q + checkpoint_ptr'(ckpt_en);
        oldest_d   = oldest_q + checkpoint_ptr'(delete_checkpoint_i);
        num_ckpt_d = num_ckpt_q + ckpt_count_t'(ckpt_en) - ckpt_count_t'(delete_checkpoint_i);
        case (recover_op_i)
            REC_CHECKPOINT: begin
                head_d     = saved_head_q[recover_label_i];
                count_d    = {1'b0, tail_d - head_d};   // Never more than 32 free, so no wrap
                label_d    = recover_label_i;
                num_ckpt_d = {1'b0, recover_label_i - oldest_d};
            end
            REC_COMMIT: begin
                // The 32 entries behind the tail hold every non-committed register
                head_d     = tail_q - phreg_t'(NUM_FREE_REGISTERS);
                count_d    = fl_count_t'(NUM_FREE_REGISTERS);
                label_d    = '0;
                oldest_d   = '0;
                num_ckpt_d = '0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_PHYS_REGISTERS; i++) begin
                entries_q[i] <= phreg_t'(i + NUM_ISA_REGISTERS);   // 32..63 up front
            end
            for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                saved_head_q[c] <= '0;
            end
            head_q     <= '0;
            tail_q     <= phreg_t'(NUM_FREE_REGISTERS);
            count_q    <= fl_count_t'(NUM_FREE_REGISTERS);
            label_q    <= '0;
            oldest_q   <= '0;
            num_ckpt_q <= '0;
        end else begin
            for (int i = 0; i < NUM_COMMIT; i++) begin
                if (push_en[i]) entries_q[push_ptr[i]] <= push_i[i].free_reg;
            end
            if (ckpt_en) saved_head_q[label_q] <= head_popped;   // Includes this rename's pop
            head_q     <= head_d;
            tail_q     <= tail_d;
            count_q    <= count_d;
            label_q    <= label_d;
            oldest_q   <= oldest_d;
            num_ckpt_q <= num_ckpt_d;
        end
    end

    assign new_dst_o = entries_q[head_q];
    assign empty_o   = (count_q == '0);

endmodule

// File: rename_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes fixed for 32 FP arch regs and 64 phys regs
// Checkpoint labels wrap at NUM_CHECKPOINTS, one copy always kept for the live map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rename_pkg;

    localparam int unsigned NUM_ISA_REGISTERS  = 32;
    localparam int unsigned NUM_PHYS_REGISTERS = 64;
    localparam int unsigned NUM_FREE_REGISTERS = NUM_PHYS_REGISTERS - NUM_ISA_REGISTERS;
    localparam int unsigned NUM_CHECKPOINTS    = 4;
    localparam int unsigned NUM_FP_WB          = 2;
    localparam int unsigned NUM_COMMIT         = 2;

    typedef logic [$clog2(NUM_ISA_REGISTERS)-1:0]  reg_t;
    typedef logic [$clog2(NUM_PHYS_REGISTERS)-1:0] phreg_t;
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0]    checkpoint_ptr;
    typedef logic [$clog2(NUM_PHYS_REGISTERS):0]   fl_count_t;    // One bit wider than a pointer
    typedef logic [$clog2(NUM_CHECKPOINTS):0]      ckpt_count_t;

    typedef enum logic [1:0] {
        REC_NONE,
        REC_CHECKPOINT,     // Branch mispredict, back to a label
        REC_COMMIT          // Exception, rebuild from the commit table
    } recover_op_e;

    typedef struct packed {
        logic   valid;
        reg_t   src1;
        reg_t   src2;
        reg_t   src3;
        logic   use_fs1;
        logic   use_fs2;
        logic   use_fs3;
        reg_t   dst;
        logic   write_dst;
        logic   do_checkpoint;
    } rename_req_t;

    typedef struct packed {
        logic   valid;
        reg_t   vaddr;
        phreg_t paddr;
    } wb_t;

    typedef struct packed {
        logic   valid;
        reg_t   old_dst;
        phreg_t new_dst;
        phreg_t free_reg;   // Previous mapping, goes back to the free list
    } commit_t;

    typedef struct packed {
        logic          valid;
        phreg_t        src1;
        phreg_t        src2;
        phreg_t        src3;
        logic          rdy1;
        logic          rdy2;
        logic          rdy3;
        phreg_t        old_dst;
        phreg_t        new_dst;
        checkpoint_ptr checkpoint;
    } rename_rsp_t;

endpackage
